// ==== gmii_phy_if.sv ====
// gmii receive pin registers and reset release sync, first stage of the receive path
`timescale 1ns/1ps

module gmii_phy_if (
    input  logic                   mac_gmii_rx_clk,
    input  logic                   rst,
    input  logic [7:0]             phy_gmii_rxd,
    input  logic                   phy_gmii_rx_dv,
    input  logic                   phy_gmii_rx_er,
    output gmii_rx_pkg::gmii_bus_t rx_bus,
    output logic                   rx_rst
);

    // reset sync, set at once, released after four clean edges
    logic [3:0] rx_rst_sr;

    always_ff @(posedge mac_gmii_rx_clk or posedge rst) begin
        if (rst) begin
            rx_rst_sr <= 4'hf;
        end else begin
            rx_rst_sr <= {1'b0, rx_rst_sr[3:1]};
        end
    end

    // last stage drives the rest of the design
    assign rx_rst = rx_rst_sr[0];

    // input registers, meant to sit in the io cells
    // phy rx clock is the same net as mac_gmii_rx_clk here
    always_ff @(posedge mac_gmii_rx_clk) begin
        rx_bus.data <= phy_gmii_rxd;
        rx_bus.dv   <= phy_gmii_rx_dv;
        rx_bus.er   <= phy_gmii_rx_er;
    end

    // downstream logic must never see rx_rst drop while the async reset is held
    a_rst_hold: assert property (@(posedge mac_gmii_rx_clk) rst |-> rx_rst)
        else $error("rx_rst low while rst high");

endmodule

// ==== gmii_rx_fcs_check.sv ====
// running crc-32 over the frame byte stream, residue check when the frame stops
`timescale 1ns/1ps

module gmii_rx_fcs_check (
    input  logic                     mac_gmii_rx_clk,
    input  logic                     rx_rst,
    input  gmii_rx_pkg::frame_beat_t beat,
    output gmii_rx_pkg::fcs_result_t fcs_res
);
    import gmii_rx_pkg::*;

    // reflected ieee 802.3 polynomial
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;

    logic [31:0] crc_q;
    logic [31:0] crc_seed;

    // one byte through the crc, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // register holds the remainder lsb first, residue constant is msb first
    function automatic logic [31:0] bit_rev32(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31 - i];
        end
        return r;
    endfunction

    // first byte restarts from all ones
    assign crc_seed = beat.start ? 32'hffff_ffff : crc_q;

    always_ff @(posedge mac_gmii_rx_clk) begin
        if (beat.valid) begin
            crc_q <= crc_byte(crc_seed, beat.data);
        end
    end

    always_ff @(posedge mac_gmii_rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            fcs_res <= '0;
        end else begin
            fcs_res.done <= beat.stop;
            if (beat.stop) begin
                fcs_res.fcs_ok <= (bit_rev32(crc_q) == CRC_RESIDUE);
            end
        end
    end

endmodule

// ==== gmii_rx_framer.sv ====
// preamble and sfd state machine, turns registered gmii samples into a frame byte stream
`timescale 1ns/1ps

module gmii_rx_framer (
    input  logic                     mac_gmii_rx_clk,
    input  logic                     rx_rst,
    input  gmii_rx_pkg::gmii_bus_t   rx_bus,
    output gmii_rx_pkg::frame_beat_t beat
);
    import gmii_rx_pkg::*;

    framer_state_t state;
    // next forwarded byte is the first after the sfd
    logic          first_pending;
    // sticky rx_er over the current frame
    logic          err_seen;
    logic          err_next;

    assign err_next = err_seen | rx_bus.er;

    always_ff @(posedge mac_gmii_rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state         <= st_idle;
            first_pending <= 1'b0;
            err_seen      <= 1'b0;
            beat          <= '0;
        end else begin
            // strobes are single cycle unless set below
            beat.valid <= 1'b0;
            beat.start <= 1'b0;
            beat.stop  <= 1'b0;
            case (state)
                st_idle: begin
                    // anything but a preamble byte at dv rise is junk until dv falls
                    if (rx_bus.dv) begin
                        state <= (rx_bus.data == GMII_PREAMBLE) ? st_preamble : st_drop;
                    end
                end
                st_preamble: begin
                    if (!rx_bus.dv) begin
                        // burst ended before sfd, nothing emitted
                        state <= st_idle;
                    end else if (rx_bus.data == GMII_SFD) begin
                        state         <= st_payload;
                        first_pending <= 1'b1;
                        err_seen      <= 1'b0;
                    end else if (rx_bus.data != GMII_PREAMBLE) begin
                        state <= st_drop;
                    end
                end
                st_payload: begin
                    if (rx_bus.dv) begin
                        beat.valid    <= 1'b1;
                        beat.data     <= rx_bus.data;
                        beat.start    <= first_pending;
                        beat.err      <= err_next;
                        first_pending <= 1'b0;
                        err_seen      <= err_next;
                    end else begin
                        // end of frame, err carries the whole-frame flag
                        beat.stop <= 1'b1;
                        beat.err  <= err_seen;
                        state     <= st_idle;
                    end
                end
                st_drop: begin
                    if (!rx_bus.dv) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_stop_not_valid: assert property (@(posedge mac_gmii_rx_clk) disable iff (rx_rst)
        !(beat.stop && beat.valid))
        else $error("stop and valid together");

    // frames are at least one idle apart, so stop never repeats
    a_stop_single: assert property (@(posedge mac_gmii_rx_clk) disable iff (rx_rst)
        beat.stop |=> !beat.stop)
        else $error("stop high two cycles");

endmodule

// ==== gmii_rx_len_check.sv ====
// frame byte counter with runt and oversize flags, result one cycle after stop
`timescale 1ns/1ps

module gmii_rx_len_check #(
    parameter int MAX_FRAME_LEN = 1518
) (
    input  logic                     mac_gmii_rx_clk,
    input  logic                     rx_rst,
    input  gmii_rx_pkg::frame_beat_t beat,
    output gmii_rx_pkg::len_result_t len_res
);
    import gmii_rx_pkg::*;

    logic [15:0] cnt_q;

    always_ff @(posedge mac_gmii_rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            cnt_q   <= '0;
            len_res <= '0;
        end else begin
            len_res.done <= beat.stop;
            if (beat.valid) begin
                // restart on the first byte, hold at all ones on overflow
                if (beat.start) begin
                    cnt_q <= 16'd1;
                end else if (cnt_q != 16'hffff) begin
                    cnt_q <= cnt_q + 16'd1;
                end
            end else if (beat.stop) begin
                // empty frame after sfd then reads zero
                cnt_q          <= '0;
                len_res.len    <= cnt_q;
                len_res.len_ok <= (cnt_q >= 16'(MIN_FRAME_LEN)) &&
                                  (cnt_q <= 16'(MAX_FRAME_LEN));
            end
        end
    end

endmodule

// ==== gmii_rx_pkg.sv ====
// shared structs, framer states and gmii constants for the receive path, compile before the rtl
package gmii_rx_pkg;

    // gmii byte values ahead of the frame
    localparam logic [7:0] GMII_PREAMBLE = 8'h55;
    localparam logic [7:0] GMII_SFD = 8'hD5;

    // crc-32 residue over frame plus fcs, msb-first form of the remainder
    localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

    // smallest legal frame, destination address through fcs
    localparam int MIN_FRAME_LEN = 64;

    // one registered gmii sample
    typedef struct packed {
        logic [7:0] data;
        logic       dv;
        logic       er;
    } gmii_bus_t;

    // one framer output cycle
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       start;
        logic       stop;
        logic       err;
    } frame_beat_t;

    typedef struct packed {
        logic done;
        logic fcs_ok;
    } fcs_result_t;

    typedef struct packed {
        logic        done;
        logic [15:0] len;
        logic        len_ok;
    } len_result_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] len;
        logic        fcs_ok;
        logic        len_ok;
        logic        phy_err;
        logic        good;
    } frame_status_t;

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_drop
    } framer_state_t;

endpackage

// ==== gmii_rx_status.sv ====
// merges fcs, length and phy error into one status pulse, keeps good and bad frame counts
`timescale 1ns/1ps

module gmii_rx_status #(
    parameter int MAX_FRAME_LEN = 1518,
    parameter int CNT_WIDTH     = 16
) (
    input  logic                       mac_gmii_rx_clk,
    input  logic                       rx_rst,
    input  logic                       phy_err_at_stop,
    input  gmii_rx_pkg::fcs_result_t   fcs_res,
    input  gmii_rx_pkg::len_result_t   len_res,
    output gmii_rx_pkg::frame_status_t status,
    output logic [CNT_WIDTH-1:0]       good_frames,
    output logic [CNT_WIDTH-1:0]       bad_frames
);
    import gmii_rx_pkg::*;

    // bits needed for the largest legal length
    localparam int LEN_W = $clog2(MAX_FRAME_LEN + 1);

    // err bit as it stood on the stop cycle, one cycle before done
    logic err_at_stop_q;
    logic len_fits;
    logic len_ok;
    logic good;

    always_ff @(posedge mac_gmii_rx_clk) begin
        err_at_stop_q <= phy_err_at_stop;
    end

    // no bits set above the length field
    assign len_fits = (len_res.len >> LEN_W) == 16'd0;
    assign len_ok   = len_res.len_ok & len_fits;
    assign good     = fcs_res.fcs_ok & len_ok & ~err_at_stop_q;

    always_ff @(posedge mac_gmii_rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            status      <= '0;
            good_frames <= '0;
            bad_frames  <= '0;
        end else begin
            status.valid <= fcs_res.done;
            if (fcs_res.done) begin
                status.len     <= len_res.len;
                status.fcs_ok  <= fcs_res.fcs_ok;
                status.len_ok  <= len_ok;
                status.phy_err <= err_at_stop_q;
                status.good    <= good;
                // exactly one counter per frame, both wrap
                if (good) begin
                    good_frames <= good_frames + 1'b1;
                end else begin
                    bad_frames <= bad_frames + 1'b1;
                end
            end
        end
    end

    // both checkers key off the same stop pulse
    a_done_aligned: assert property (@(posedge mac_gmii_rx_clk) disable iff (rx_rst)
        fcs_res.done == len_res.done)
        else $error("fcs and length results out of step");

endmodule

// ==== gmii_rx_top.f ====
gmii_rx_pkg.sv
gmii_phy_if.sv
gmii_rx_framer.sv
gmii_rx_fcs_check.sv
gmii_rx_len_check.sv
gmii_rx_status.sv
gmii_rx_top.sv
tb_gmii_rx_top.sv

// ==== gmii_rx_top.sv ====
// gmii receive front end top level, pins in, per-frame status and counters out
`timescale 1ns/1ps

module gmii_rx_top #(
    parameter int MAX_FRAME_LEN = 1518,
    parameter int CNT_WIDTH     = 16
) (
    input  logic                       mac_gmii_rx_clk,
    input  logic                       rst,
    input  logic [7:0]                 phy_gmii_rxd,
    input  logic                       phy_gmii_rx_dv,
    input  logic                       phy_gmii_rx_er,
    output gmii_rx_pkg::frame_status_t status,
    output logic [CNT_WIDTH-1:0]       good_frames,
    output logic [CNT_WIDTH-1:0]       bad_frames
);
    import gmii_rx_pkg::*;

    gmii_bus_t   rx_bus;
    logic        rx_rst;
    frame_beat_t beat;
    fcs_result_t fcs_res;
    len_result_t len_res;

    gmii_phy_if i_gmii_phy_if (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rst             (rst),
        .phy_gmii_rxd    (phy_gmii_rxd),
        .phy_gmii_rx_dv  (phy_gmii_rx_dv),
        .phy_gmii_rx_er  (phy_gmii_rx_er),
        .rx_bus          (rx_bus),
        .rx_rst          (rx_rst)
    );

    gmii_rx_framer i_gmii_rx_framer (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rx_rst          (rx_rst),
        .rx_bus          (rx_bus),
        .beat            (beat)
    );

    // both checkers run side by side on the same beat stream
    gmii_rx_fcs_check i_gmii_rx_fcs_check (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rx_rst          (rx_rst),
        .beat            (beat),
        .fcs_res         (fcs_res)
    );

    gmii_rx_len_check #(
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) i_gmii_rx_len_check (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rx_rst          (rx_rst),
        .beat            (beat),
        .len_res         (len_res)
    );

    // beat.err is only meaningful on stop, status samples it there
    gmii_rx_status #(
        .MAX_FRAME_LEN (MAX_FRAME_LEN),
        .CNT_WIDTH     (CNT_WIDTH)
    ) i_gmii_rx_status (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rx_rst          (rx_rst),
        .phy_err_at_stop (beat.err),
        .fcs_res         (fcs_res),
        .len_res         (len_res),
        .status          (status),
        .good_frames     (good_frames),
        .bad_frames      (bad_frames)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the gmii receive testbench with verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gmii_rx_top -f gmii_rx_top.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== tb_gmii_rx_top.sv ====
// testbench for the gmii receive front end, sends random frames and checks each frame status
`timescale 1ns/1ps

module tb_gmii_rx_top;
    import gmii_rx_pkg::*;

    localparam int MAX_FRAME_LEN = 1518;
    localparam int CNT_WIDTH     = 16;
    localparam int IDLE_CYCLES   = 12;
    localparam int STATUS_WAIT   = 2000;

    logic                 mac_gmii_rx_clk = 1'b0;
    logic                 rst;
    logic [7:0]           phy_gmii_rxd;
    logic                 phy_gmii_rx_dv;
    logic                 phy_gmii_rx_er;
    frame_status_t        status;
    logic [CNT_WIDTH-1:0] good_frames;
    logic [CNT_WIDTH-1:0] bad_frames;

    // current frame, destination address through fcs
    logic [7:0]           frame_buf [];
    logic [7:0]           burst [];
    logic [CNT_WIDTH-1:0] exp_good = '0;
    logic [CNT_WIDTH-1:0] exp_bad = '0;
    int                   checks = 0;
    int                   errors = 0;
    int                   tests = 0;

    gmii_rx_top #(
        .MAX_FRAME_LEN (MAX_FRAME_LEN),
        .CNT_WIDTH     (CNT_WIDTH)
    ) i_gmii_rx_top (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rst             (rst),
        .phy_gmii_rxd    (phy_gmii_rxd),
        .phy_gmii_rx_dv  (phy_gmii_rx_dv),
        .phy_gmii_rx_er  (phy_gmii_rx_er),
        .status          (status),
        .good_frames     (good_frames),
        .bad_frames      (bad_frames)
    );

    always #5 mac_gmii_rx_clk = ~mac_gmii_rx_clk;

    // ethernet fcs over the first count bytes, value as it goes on the wire
    function automatic logic [31:0] crc32(input logic [7:0] bytes [], input int count);
        logic [31:0] crc;
        crc = 32'hffff_ffff;
        for (int n = 0; n < count; n++) begin
            for (int b = 0; b < 8; b++) begin
                if (crc[0] != bytes[n][b]) begin
                    crc = (crc >> 1) ^ 32'hEDB88320;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    // expected status, fcs good when the last four bytes match the crc of the rest
    function automatic frame_status_t expected_status(input logic [7:0] bytes [],
                                                      input bit er_inj);
        frame_status_t s;
        logic [31:0]   fcs_rx;
        int            n;
        n = bytes.size();
        fcs_rx = {bytes[n-1], bytes[n-2], bytes[n-3], bytes[n-4]};
        s = '0;
        s.valid   = 1'b1;
        s.len     = 16'(n);
        s.fcs_ok  = (crc32(bytes, n - 4) == fcs_rx);
        s.len_ok  = (n >= MIN_FRAME_LEN) && (n <= MAX_FRAME_LEN);
        s.phy_err = er_inj;
        s.good    = s.fcs_ok && s.len_ok && !s.phy_err;
        return s;
    endfunction

    // random payload with its fcs appended
    task automatic build_frame(input int len);
        logic [31:0] rnd;
        logic [31:0] fcs;
        frame_buf = new[len];
        for (int i = 0; i < len - 4; i++) begin
            rnd = $urandom;
            frame_buf[i] = rnd[7:0];
        end
        fcs = crc32(frame_buf, len - 4);
        // fcs goes out low byte first
        frame_buf[len-4] = fcs[7:0];
        frame_buf[len-3] = fcs[15:8];
        frame_buf[len-2] = fcs[23:16];
        frame_buf[len-1] = fcs[31:24];
    endtask

    // raw bytes with dv high, er on one index if asked, then the idle gap
    task automatic send_raw(input logic [7:0] raw [], input int er_idx);
        for (int i = 0; i < raw.size(); i++) begin
            @(negedge mac_gmii_rx_clk);
            phy_gmii_rxd   = raw[i];
            phy_gmii_rx_dv = 1'b1;
            phy_gmii_rx_er = (i == er_idx);
        end
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge mac_gmii_rx_clk);
            phy_gmii_rxd   = 8'h00;
            phy_gmii_rx_dv = 1'b0;
            phy_gmii_rx_er = 1'b0;
        end
    endtask

    // seven preamble bytes and the sfd ahead of the frame
    task automatic send_frame(input logic [7:0] bytes [], input int er_idx);
        logic [7:0] raw [];
        raw = new[bytes.size() + 8];
        for (int i = 0; i < 7; i++) begin
            raw[i] = GMII_PREAMBLE;
        end
        raw[7] = GMII_SFD;
        for (int i = 0; i < bytes.size(); i++) begin
            raw[i+8] = bytes[i];
        end
        send_raw(raw, (er_idx < 0) ? -1 : er_idx + 8);
    endtask

    task automatic compare_status(input frame_status_t got, input frame_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0d ns: status len=%0d fcs_ok=%0b len_ok=%0b phy_err=%0b good=%0b, %s",
                     $time, got.len, got.fcs_ok, got.len_ok, got.phy_err, got.good,
                     $sformatf("expected len=%0d fcs_ok=%0b len_ok=%0b phy_err=%0b good=%0b",
                               exp.len, exp.fcs_ok, exp.len_ok, exp.phy_err, exp.good));
        end
    endtask

    task automatic compare_counts(input logic [CNT_WIDTH-1:0] got,
                                  input logic [CNT_WIDTH-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // status is registered at the rising edge, so read it at the falling one
    task automatic check_status(input frame_status_t exp);
        bit seen;
        seen = 1'b0;
        for (int waited = 0; waited < STATUS_WAIT && !seen; waited++) begin
            @(negedge mac_gmii_rx_clk);
            seen = status.valid;
        end
        if (!seen) begin
            errors++;
            $display("timeout: no frame status within %0d cycles", STATUS_WAIT);
        end else begin
            compare_status(status, exp);
        end
    endtask

    task automatic expect_no_status(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge mac_gmii_rx_clk);
            if (status.valid) begin
                errors++;
                $display("a frame status came out for a burst that should have been dropped");
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s did not pass", name);
        end
    endtask

    // one frame end to end, optional bit flip and rx_er index
    task automatic frame_test(input string name, input int len, input bit flip,
                              input int er_idx);
        frame_status_t exp;
        int            errs_before;
        build_frame(len);
        if (flip) begin
            frame_buf[len/2][3] = ~frame_buf[len/2][3];
        end
        exp = expected_status(frame_buf, er_idx >= 0);
        errs_before = errors;
        fork
            send_frame(frame_buf, er_idx);
            check_status(exp);
        join
        if (exp.good) begin
            exp_good++;
        end else begin
            exp_bad++;
        end
        report_test(name, errs_before);
    endtask

    task automatic drop_test(input string name, input logic [7:0] raw []);
        int errs_before;
        errs_before = errors;
        fork
            send_raw(raw, -1);
            expect_no_status(raw.size() + IDLE_CYCLES);
        join
        report_test(name, errs_before);
    endtask

    initial begin
        logic [31:0] rnd;
        void'($urandom(32'h66197d35));
        rst            = 1'b1;
        phy_gmii_rxd   = 8'h00;
        phy_gmii_rx_dv = 1'b0;
        phy_gmii_rx_er = 1'b0;
        repeat (4) @(negedge mac_gmii_rx_clk);
        rst = 1'b0;
        // internal reset holds four more cycles
        repeat (8) @(negedge mac_gmii_rx_clk);

        frame_test("good_64", 64, 1'b0, -1);
        frame_test("good_100", 100, 1'b0, -1);
        frame_test("good_1518", 1518, 1'b0, -1);
        frame_test("fcs_bit_flip", 100, 1'b1, -1);
        frame_test("runt_60", 60, 1'b0, -1);
        frame_test("oversize_1519", 1519, 1'b0, -1);
        frame_test("rx_er_mid_frame", 100, 1'b0, 50);

        // preamble only, dv drops before any sfd
        burst = new[7];
        foreach (burst[i]) begin
            burst[i] = GMII_PREAMBLE;
        end
        drop_test("no_sfd", burst);

        // one corrupted preamble byte, the rest of a frame follows
        burst = new[72];
        for (int i = 0; i < 72; i++) begin
            rnd = $urandom;
            burst[i] = rnd[7:0];
        end
        for (int i = 0; i < 7; i++) begin
            burst[i] = GMII_PREAMBLE;
        end
        burst[3] = 8'h5A;
        burst[7] = GMII_SFD;
        drop_test("bad_preamble", burst);

        frame_test("good_after_drop", 64, 1'b0, -1);

        @(negedge mac_gmii_rx_clk);
        compare_counts(good_frames, exp_good, "good_frames");
        compare_counts(bad_frames, exp_bad, "bad_frames");
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
